//--- src.f
src/median_pkg.sv
src/sort_if.sv
src/frame_store.sv
src/column_history.sv
src/rank_cell.sv
src/rank_sorter.sv
src/scan_control.sv
src/median_filter_top.sv
verification/median_filter_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the median filter simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module median_filter_tb -f src.f -o median_filter_sim

./obj_dir/median_filter_sim 2>&1 | tee sim.log

if grep -q "All tests passed!" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- verification/median_filter_tb.sv
// median filter testbench
module median_filter_tb import median_pkg::*; ();

  localparam int SEED         = 32'hd807;
  localparam int TIMEOUT_CYC  = 4000;
  localparam int FILL_RANDOM  = 0;
  localparam int FILL_MAX     = 1;
  localparam int FILL_CHECKER = 2;

  logic   CLK = 1'b0;
  logic   RST;
  pixel_t din;
  logic   in_en;
  logic   busy;
  logic   out_valid;
  pixel_t dout;

  pixel_t frame   [N_PIX];
  pixel_t exp_med [N_PIX];
  int     sent_cnt;
  int     frame_base;
  int     seen_total;

  median_filter_top u_median_filter_top (
    .CLK       (CLK),
    .RST       (RST),
    .din       (din),
    .in_en     (in_en),
    .busy      (busy),
    .out_valid (out_valid),
    .dout      (dout)
  );

  always #20 CLK = ~CLK;

  task automatic stop_on_failure();
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input int got, input int want);
    assert (got == want) else begin
      $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, want);
      stop_on_failure();
    end
  endtask

  // 3x3 window sorted ascending, pixels off the image count as zero
  function automatic pixel_t window_median(input int cx, input int cy);
    pixel_t win [N_CELLS];
    pixel_t tmp;
    int     n;
    int     x;
    int     y;
    n = 0;
    for (int dy = -WIN_HALF; dy <= WIN_HALF; dy++) begin
      for (int dx = -WIN_HALF; dx <= WIN_HALF; dx++) begin
        x = cx + dx;
        y = cy + dy;
        if (x >= 0 && x < IMG_W && y >= 0 && y < IMG_H) begin
          win[n] = frame[y * IMG_W + x];
        end else begin
          win[n] = '0;
        end
        n++;
      end
    end
    for (int i = 1; i < N_CELLS; i++) begin
      for (int j = i; j > 0 && win[j - 1] > win[j]; j--) begin
        tmp        = win[j];
        win[j]     = win[j - 1];
        win[j - 1] = tmp;
      end
    end
    return win[MED_RANK];
  endfunction

  task automatic fill_frame(input int kind);
    for (int a = 0; a < N_PIX; a++) begin
      case (kind)
        FILL_MAX:     frame[a] = PIX_MAX;
        FILL_CHECKER: frame[a] = (((a / IMG_W) + (a % IMG_W)) % 2 == 1) ? PIX_MAX : PIX_MIN;
        default:      frame[a] = pixel_t'($urandom());
      endcase
    end
  endtask

  task automatic compute_expected();
    for (int a = 0; a < N_PIX; a++) begin
      exp_med[a] = window_median(a % IMG_W, a / IMG_W);
    end
  endtask

  // load one frame, then hold until busy falls
  task automatic run_frame(input int kind, input bit junk);
    int cyc;
    fill_frame(kind);
    compute_expected();
    sent_cnt = 0;
    while (sent_cnt < N_PIX) begin
      @(negedge CLK);
      // output count of the new frame starts with its first pixel
      if (sent_cnt == 0) begin
        frame_base = seen_total;
      end
      check_value("busy", int'(busy), 0);
      in_en    = 1'b1;
      din      = frame[sent_cnt];
      sent_cnt = sent_cnt + 1;
    end
    @(negedge CLK);
    in_en = 1'b0;
    check_value("busy", int'(busy), 1);
    cyc = 0;
    while (busy) begin
      // strobes during filtering must be ignored
      if (junk) begin
        in_en = 1'b1;
        din   = pixel_t'($urandom());
      end
      @(negedge CLK);
      cyc++;
      if (cyc > TIMEOUT_CYC) begin
        $display("timeout while waiting for busy to fall");
        stop_on_failure();
      end
    end
    in_en = 1'b0;
    check_value("out_valid count", seen_total - frame_base, N_PIX);
  endtask

  // output checker, sampled away from the active edge
  always @(negedge CLK) begin
    if (RST) begin
      seen_total = 0;
    end else if (out_valid) begin
      assert (seen_total - frame_base < N_PIX) else begin
        $display("out_valid pulsed more often than the frame has pixels");
        stop_on_failure();
      end
      check_value("dout", int'(dout), int'(exp_med[seen_total - frame_base]));
      seen_total = seen_total + 1;
    end
  end

  a_valid_busy: assert property (@(posedge CLK) disable iff (RST) out_valid |-> busy)
    else begin
      $display("out_valid pulsed while busy was low");
      stop_on_failure();
    end

  a_valid_pulse: assert property (@(posedge CLK) disable iff (RST) out_valid |=> !out_valid)
    else begin
      $display("out_valid stayed high for more than one cycle");
      stop_on_failure();
    end

  a_busy_rise: assert property (@(posedge CLK) disable iff (RST) $rose(busy) |-> sent_cnt == N_PIX)
    else begin
      $display("[ERROR] %0t sent_cnt: got %0d expected %0d", $time, sent_cnt, N_PIX);
      stop_on_failure();
    end

  a_busy_fall: assert property (@(posedge CLK) disable iff (RST)
                                $fell(busy) |-> seen_total - frame_base == N_PIX)
    else begin
      $display("[ERROR] %0t out_valid count: got %0d expected %0d", $time,
               seen_total - frame_base, N_PIX);
      stop_on_failure();
    end

  initial begin
    void'($urandom(SEED));
    RST        = 1'b1;
    in_en      = 1'b0;
    din        = '0;
    frame_base = 0;
    sent_cnt   = 0;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    check_value("busy", int'(busy), 0);
    check_value("out_valid", int'(out_valid), 0);
    check_value("dout", int'(dout), 0);
    run_frame(FILL_RANDOM, 1'b1);
    run_frame(FILL_MAX, 1'b0);
    run_frame(FILL_CHECKER, 1'b0);
    // reload from address zero after the previous frame
    run_frame(FILL_RANDOM, 1'b0);
    check_value("total outputs", seen_total, 4 * N_PIX);
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- src/median_filter_top.sv
// 3x3 median filter top
module median_filter_top import median_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  pixel_t din,
  input  logic   in_en,
  output logic   busy,
  output logic   out_valid,
  output pixel_t dout
);

  logic      wr_en;
  pix_addr_t wr_addr;
  coord_t    rd_x;
  coord_t    rd_y;

  sort_if sif ();

  scan_control u_scan_control (
    .CLK       (CLK),
    .RST       (RST),
    .in_en     (in_en),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .rd_x      (rd_x),
    .rd_y      (rd_y),
    .busy      (busy),
    .out_valid (out_valid),
    .dout      (dout),
    .sif       (sif.ctrl)
  );

  // entering pixels
  frame_store u_frame_store (
    .CLK     (CLK),
    .RST     (RST),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .din     (din),
    .rd_x    (rd_x),
    .rd_y    (rd_y),
    .sif     (sif.src)
  );

  // leaving pixels
  column_history u_column_history (
    .CLK (CLK),
    .RST (RST),
    .sif (sif.hist)
  );

  rank_sorter u_rank_sorter (
    .CLK (CLK),
    .RST (RST),
    .sif (sif.sort)
  );

endmodule

//--- src/scan_control.sv
// raster scan controller
module scan_control import median_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  input  logic      in_en,
  output logic      wr_en,
  output pix_addr_t wr_addr,
  output coord_t    rd_x,
  output coord_t    rd_y,
  output logic      busy,
  output logic      out_valid,
  output pixel_t    dout,
  sort_if.ctrl      sif
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  coord_t      cx;
  coord_t      cy;
  win_idx_t    rd_cnt;
  logic        last_pix;
  logic        last_rd;
  logic        row_end;
  logic        emit;

  assign busy     = (state != ST_LOAD);
  assign wr_en    = in_en && !busy;
  assign last_pix = wr_en && (wr_addr == pix_addr_t'(N_PIX - 1));
  assign last_rd  = (rd_cnt == win_idx_t'(WIN - 1));
  assign row_end  = (cx == coord_t'(IMG_W - 1));

  // warm-up steps have their centre left of column 0
  assign emit = (state == ST_EMIT) && (cx >= coord_t'(0));

  // cx is the window centre, reads fetch the entering column
  assign rd_x = cx + coord_t'(WIN_HALF);
  assign rd_y = cy + coord_t'(rd_cnt) - coord_t'(WIN_HALF);

  assign sif.clr = (state == ST_CLEAR);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_LOAD: begin
        if (last_pix) begin
          state_nxt = ST_CLEAR;
        end
      end
      ST_CLEAR: begin
        // one row past the bottom means the frame is done
        state_nxt = (cy == coord_t'(IMG_H)) ? ST_LOAD : ST_READ;
      end
      ST_READ: begin
        if (last_rd) begin
          state_nxt = ST_SETTLE;
        end
      end
      ST_SETTLE: begin
        state_nxt = ST_EMIT;
      end
      ST_EMIT: begin
        state_nxt = row_end ? ST_CLEAR : ST_READ;
      end
      default: begin
        state_nxt = ST_LOAD;
      end
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= ST_LOAD;
      wr_addr <= '0;
      cx      <= coord_t'(-WIN_HALF - 1);
      cy      <= '0;
      rd_cnt  <= '0;
    end else begin
      state <= state_nxt;
      // wraps back to zero after the last pixel
      if (wr_en) begin
        wr_addr <= wr_addr + 1'b1;
      end
      case (state)
        ST_CLEAR: begin
          if (cy == coord_t'(IMG_H)) begin
            cy <= '0;
          end
        end
        ST_READ: begin
          rd_cnt <= last_rd ? '0 : rd_cnt + 1'b1;
        end
        ST_EMIT: begin
          if (row_end) begin
            cx <= coord_t'(-WIN_HALF - 1);
            cy <= cy + coord_t'(1);
          end else begin
            cx <= cx + coord_t'(1);
          end
        end
        default: begin
        end
      endcase
    end
  end

  // upd trails each read by the frame store latency
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sif.upd   <= 1'b0;
      sif.row   <= '0;
      out_valid <= 1'b0;
      dout      <= '0;
    end else begin
      sif.upd   <= (state == ST_READ);
      sif.row   <= rd_cnt;
      out_valid <= emit;
      if (emit) begin
        dout <= sif.med;
      end
    end
  end

endmodule

//--- src/rank_sorter.sv
// rank order sorter
module rank_sorter import median_pkg::*; (
  input  logic CLK,
  input  logic RST,
  sort_if.sort sif
);

  // chain[0] and chain[N_CELLS+1] are the fixed ends
  pixel_t chain [N_CELLS + 2];
  pixel_t ins_eff;
  pixel_t del_eff;

  // equal insert and delete leave every cell unchanged
  assign ins_eff = sif.upd ? sif.ins : PIX_MAX;
  assign del_eff = sif.upd ? sif.del : PIX_MAX;

  assign chain[0]           = PIX_MIN;
  assign chain[N_CELLS + 1] = PIX_MAX;

  for (genvar i = 0; i < N_CELLS; i++) begin : g_cell
    rank_cell u_rank_cell (
      .CLK (CLK),
      .RST (RST),
      .clr (sif.clr),
      .ins (ins_eff),
      .del (del_eff),
      .pre (chain[i]),
      .nxt (chain[i + 2]),
      .val (chain[i + 1])
    );
  end

  assign sif.med = chain[MED_RANK + 1];

endmodule

//--- src/rank_cell.sv
// sorted array cell
module rank_cell import median_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  logic   clr,
  input  pixel_t ins,
  input  pixel_t del,
  input  pixel_t pre,
  input  pixel_t nxt,
  output pixel_t val
);

  pixel_t val_nxt;

  always_comb begin
    val_nxt = val;
    if (ins < del) begin
      // values in (ins, del] slide up one rank
      if ((val > ins) && (val <= del)) begin
        val_nxt = (pre > ins) ? pre : ins;
      end
    end else if (ins > del) begin
      // values in [del, ins) slide down one rank
      if ((val < ins) && (val >= del)) begin
        val_nxt = (nxt < ins) ? nxt : ins;
      end
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      val <= PIX_MAX;
    end else if (clr) begin
      val <= PIX_MAX;
    end else begin
      val <= val_nxt;
    end
  end

endmodule

//--- src/column_history.sv
// window column history
module column_history import median_pkg::*; (
  input  logic CLK,
  input  logic RST,
  sort_if.hist sif
);

  // per window row, entry 0 is the oldest
  pixel_t hist [WIN][WIN];

  assign sif.del = hist[sif.row][0];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int r = 0; r < WIN; r++) begin
        for (int k = 0; k < WIN; k++) begin
          hist[r][k] <= PIX_MAX;
        end
      end
    end else if (sif.clr) begin
      // placeholders match the cleared sorter cells
      for (int r = 0; r < WIN; r++) begin
        for (int k = 0; k < WIN; k++) begin
          hist[r][k] <= PIX_MAX;
        end
      end
    end else if (sif.upd) begin
      for (int k = 0; k < WIN - 1; k++) begin
        hist[sif.row][k] <= hist[sif.row][k + 1];
      end
      hist[sif.row][WIN - 1] <= sif.ins;
    end
  end

endmodule

//--- src/frame_store.sv
// frame register store
module frame_store import median_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  input  logic      wr_en,
  input  pix_addr_t wr_addr,
  input  pixel_t    din,
  input  coord_t    rd_x,
  input  coord_t    rd_y,
  sort_if.src       sif
);

  pixel_t    mem [N_PIX];
  logic      in_img;
  pix_addr_t rd_addr;

  // raster write while loading
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= din;
    end
  end

  assign in_img = (rd_x >= coord_t'(0)) && (rd_x < coord_t'(IMG_W)) &&
                  (rd_y >= coord_t'(0)) && (rd_y < coord_t'(IMG_H));

  // only meaningful while in_img is set
  assign rd_addr = pix_addr_t'(rd_y) * pix_addr_t'(IMG_W) + pix_addr_t'(rd_x);

  // outside the image reads as zero
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sif.ins <= PIX_MIN;
    end else if (in_img) begin
      sif.ins <= mem[rd_addr];
    end else begin
      sif.ins <= PIX_MIN;
    end
  end

endmodule

//--- src/sort_if.sv
// sorter update bus
interface sort_if import median_pkg::*; ();

  logic     upd;
  logic     clr;
  win_idx_t row;
  pixel_t   ins;
  pixel_t   del;
  pixel_t   med;

  // step sequencing
  modport ctrl (output upd, output clr, output row, input med);

  // entering pixel from the frame
  modport src (output ins);

  // leaving pixel per window row
  modport hist (input upd, input clr, input row, input ins, output del);

  modport sort (input upd, input clr, input ins, input del, output med);

endinterface

//--- src/median_pkg.sv
// median filter shared definitions
package median_pkg;

  // frame geometry
  localparam int IMG_W = 16;
  localparam int IMG_H = 16;
  localparam int N_PIX = IMG_W * IMG_H;

  // window and sorter geometry
  localparam int WIN      = 3;
  localparam int WIN_HALF = WIN / 2;
  localparam int N_CELLS  = WIN * WIN;
  localparam int MED_RANK = N_CELLS / 2;

  typedef logic [7:0] pixel_t;

  // signed so the scan can step past either image edge
  typedef logic signed [5:0] coord_t;

  typedef logic [7:0] pix_addr_t;
  typedef logic [1:0] win_idx_t;

  // fixed ends of the sorted chain
  localparam pixel_t PIX_MIN = '0;
  localparam pixel_t PIX_MAX = '1;

  typedef enum logic [2:0] {
    ST_LOAD,
    ST_CLEAR,
    ST_READ,
    ST_SETTLE,
    ST_EMIT
  } ctrl_state_t;

endpackage
